//--- design/icache_bank_pkg.sv
/*
 * Instruction cache bank package
 * Address split, way count, miss FIFO depth, bank FSM states and
 * the packed types shared by the tag check, the controller and the FIFO
 */

`default_nettype none

package icache_bank_pkg;

   ////////////////////
   // Address split
   ////////////////////

   localparam int ADDR_W   = 32;
   // Byte offset inside a 16-byte line
   localparam int OFFSET_W = 4;
   localparam int SET_W    = 5;
   localparam int TAG_W    = 8;
   // Set index sits right above the offset, tag right above the set
   localparam int SET_LSB  = OFFSET_W;
   localparam int TAG_LSB  = OFFSET_W + SET_W;

   ////////////////////
   // Ways and queues
   ////////////////////

   localparam int NB_WAYS         = 4;
   localparam int WAY_IDX_W       = $clog2(NB_WAYS);
   localparam int MISS_FIFO_DEPTH = 16;
   localparam int FIFO_PTR_W      = $clog2(MISS_FIFO_DEPTH);
   // One extra bit so that a full FIFO can be counted
   localparam int FIFO_CNT_W      = FIFO_PTR_W + 1;
   // Nonzero, an all-zero LFSR never leaves zero
   localparam logic [7:0] LFSR_SEED = 8'd1;

   // One way of the tag memory
   typedef struct packed {
      logic             valid;
      logic [TAG_W-1:0] tag;
   } tag_entry_t;

   // All ways of one set
   typedef tag_entry_t [NB_WAYS-1:0] tag_ways_t;

   typedef logic [NB_WAYS-1:0] way_oh_t;

   // One queued refill toward the main cache controller
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      way_oh_t           way;
   } refill_req_t;

   typedef enum logic [2:0] {
      DISABLED,
      WAIT_IDLE,
      OPERATIVE,
      REQ_REFILL,
      ENTER_BYPASS
   } bank_state_e;

endpackage

`default_nettype wire

//--- design/icache_way_lfsr.sv
/*
 * Replacement way LFSR
 * 8-bit Fibonacci LFSR, taps 8 6 5 4, decoded to a one-hot way
 */

`timescale 1ns/1ns
`default_nettype none

module icache_way_lfsr
(
   input  wire logic                      clk,
   input  wire logic                      rst_n,
   input  wire logic                      step_i,
   output icache_bank_pkg::way_oh_t       rand_way_o
);
   import icache_bank_pkg::*;

   logic [7:0] lfsr_q;
   logic       feedback;

   // Taps 8 6 5 4 are bits 7 5 4 3
   assign feedback = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         lfsr_q <= LFSR_SEED;
      end
      else if (step_i)
      begin
         lfsr_q <= {lfsr_q[6:0], feedback};
      end
   end

   // Low bits pick the way
   assign rand_way_o = way_oh_t'(1) << lfsr_q[WAY_IDX_W-1:0];

endmodule

`default_nettype wire

//--- design/icache_tag_check.sv
/*
 * Tag check for one cache set
 * Compares the pending fetch tag with every valid way, and finds
 * the highest-numbered invalid way for allocation
 */

`timescale 1ns/1ns
`default_nettype none

module icache_tag_check
(
   input  wire icache_bank_pkg::tag_ways_t           tag_rdata_i,
   input  wire logic [icache_bank_pkg::ADDR_W-1:0]   pend_addr_i,
   output logic                                      hit_o,
   output logic                                      all_valid_o,
   output icache_bank_pkg::way_oh_t                  free_way_o
);
   import icache_bank_pkg::*;

   logic [TAG_W-1:0]   pend_tag;
   logic [NB_WAYS-1:0] way_valid;
   logic [NB_WAYS-1:0] way_match;

   assign pend_tag = pend_addr_i[TAG_LSB +: TAG_W];

   ////////////////////
   // Per-way compare
   ////////////////////

   for (genvar w = 0; w < NB_WAYS; w++)
   begin : g_way
      assign way_valid[w] = tag_rdata_i[w].valid;
      // Stale tags in invalid ways never hit
      assign way_match[w] = tag_rdata_i[w].valid && (tag_rdata_i[w].tag == pend_tag);
   end

   assign hit_o       = |way_match;
   assign all_valid_o = &way_valid;

   // Upward scan, the last invalid way found wins
   always_comb
   begin
      free_way_o = '0;
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (!way_valid[w])
         begin
            free_way_o    = '0;
            free_way_o[w] = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- design/icache_miss_fifo.sv
/*
 * Miss FIFO
 * Circular buffer of pending refill requests toward the main
 * cache controller, valid/grant handshake on both sides
 */

`timescale 1ns/1ns
`default_nettype none

module icache_miss_fifo
(
   input  wire logic                          clk,
   input  wire logic                          rst_n,
   input  wire logic                          push_valid_i,
   input  wire icache_bank_pkg::refill_req_t  push_data_i,
   output logic                               push_gnt_o,
   output logic                               pop_valid_o,
   output icache_bank_pkg::refill_req_t       pop_data_o,
   input  wire logic                          pop_gnt_i
);
   import icache_bank_pkg::*;

   refill_req_t           mem [MISS_FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr_q;
   logic [FIFO_PTR_W-1:0] rd_ptr_q;
   logic [FIFO_CNT_W-1:0] count_q;
   logic                  push;
   logic                  pop;

   ////////////////////
   // Handshakes
   ////////////////////

   assign push_gnt_o  = (count_q != FIFO_CNT_W'(MISS_FIFO_DEPTH));
   assign pop_valid_o = (count_q != '0);
   // Head entry, stable until popped
   assign pop_data_o  = mem[rd_ptr_q];

   assign push = push_valid_i & push_gnt_o;
   assign pop  = pop_valid_o & pop_gnt_i;

   ////////////////////
   // Pointers
   ////////////////////

   // Depth is a power of two, pointers wrap by themselves
   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop)
         begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // Simultaneous push and pop leave the count alone
         if (push && !pop)
         begin
            count_q <= count_q + 1'b1;
         end
         else if (pop && !push)
         begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   // Storage
   always_ff @(posedge clk)
   begin
      if (push)
      begin
         mem[wr_ptr_q] <= push_data_i;
      end
   end

endmodule

`default_nettype wire

//--- design/icache_bank_ctrl.sv
/*
 * Instruction cache bank controller
 * Bank FSM for enable, disable and refill back-pressure, plus the
 * one-deep fetch stage that holds the address under tag check.
 * On a miss it picks the victim way and pushes a refill request
 */

`timescale 1ns/1ns
`default_nettype none

module icache_bank_ctrl
(
   input  wire logic                                 clk,
   input  wire logic                                 rst_n,
   input  wire logic                                 fetch_req_i,
   input  wire logic [icache_bank_pkg::ADDR_W-1:0]   fetch_addr_i,
   input  wire logic                                 bypass_icache_i,
   input  wire logic                                 refill_idle_i,
   input  wire logic                                 bypass_done_i,
   input  wire logic                                 hit_i,
   input  wire logic                                 all_valid_i,
   input  wire icache_bank_pkg::way_oh_t             free_way_i,
   input  wire icache_bank_pkg::way_oh_t             rand_way_i,
   input  wire logic                                 push_gnt_i,
   output logic                                      fetch_gnt_o,
   output logic                                      fetch_rvalid_o,
   output logic                                      tag_read_req_o,
   output logic [icache_bank_pkg::SET_W-1:0]         tag_read_set_o,
   output logic [icache_bank_pkg::ADDR_W-1:0]        pend_addr_o,
   output logic                                      push_valid_o,
   output icache_bank_pkg::refill_req_t              push_data_o,
   output logic                                      lfsr_step_o,
   output logic                                      cache_is_bypassed_o
);
   import icache_bank_pkg::*;

   bank_state_e       state_q;
   bank_state_e       state_d;
   // Fetch stage: a fetch is in flight, waiting for its tag check
   logic              pend_q;
   logic              pend_d;
   logic [ADDR_W-1:0] pend_addr_q;
   way_oh_t           victim_way;

   ////////////////////
   // Victim and push
   ////////////////////

   // Random way only when no way of the set is free
   assign victim_way = all_valid_i ? rand_way_i : free_way_i;

   // Full fetch address goes out, the main controller aligns it to the line
   assign push_data_o.addr = pend_addr_q;
   assign push_data_o.way  = victim_way;

   // One LFSR step per accepted random replacement
   assign lfsr_step_o = push_valid_o & push_gnt_i & all_valid_i;

   assign tag_read_set_o = fetch_addr_i[SET_LSB +: SET_W];
   assign pend_addr_o    = pend_addr_q;

   ////////////////////
   // Registers
   ////////////////////

   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q <= DISABLED;
         pend_q  <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         pend_q  <= pend_d;
      end
   end

   // Address captured together with the tag read
   always_ff @(posedge clk)
   begin
      if (tag_read_req_o)
      begin
         pend_addr_q <= fetch_addr_i;
      end
   end

   ////////////////////
   // Bank FSM
   ////////////////////

   always_comb
   begin
      state_d             = state_q;
      pend_d              = pend_q;
      fetch_gnt_o         = 1'b0;
      fetch_rvalid_o      = 1'b0;
      tag_read_req_o      = 1'b0;
      push_valid_o        = 1'b0;
      cache_is_bypassed_o = 1'b0;

      case (state_q)
         // Cache off, fetches are served around the bank
         DISABLED:
         begin
            cache_is_bypassed_o = 1'b1;
            fetch_gnt_o         = 1'b1;
            pend_d              = 1'b0;
            if (!bypass_icache_i)
            begin
               state_d = WAIT_IDLE;
            end
         end

         // Enabling, the external refill path must drain first
         WAIT_IDLE:
         begin
            cache_is_bypassed_o = 1'b1;
            if (refill_idle_i)
            begin
               state_d = OPERATIVE;
            end
         end

         OPERATIVE:
         begin
            if (bypass_icache_i)
            begin
               // Disable request: no new grant, finish what is in flight
               if (!pend_q)
               begin
                  state_d = DISABLED;
               end
               else if (hit_i)
               begin
                  fetch_rvalid_o = 1'b1;
                  pend_d         = 1'b0;
                  state_d        = ENTER_BYPASS;
               end
               else
               begin
                  // Last miss goes out through the refill state
                  state_d = REQ_REFILL;
               end
            end
            else
            begin
               if (!pend_q)
               begin
                  fetch_gnt_o = 1'b1;
               end
               else if (hit_i)
               begin
                  fetch_rvalid_o = 1'b1;
                  fetch_gnt_o    = 1'b1;
               end
               else
               begin
                  // Miss, completes at once if the FIFO takes it
                  push_valid_o   = 1'b1;
                  fetch_gnt_o    = push_gnt_i;
                  fetch_rvalid_o = push_gnt_i;
                  if (!push_gnt_i)
                  begin
                     state_d = REQ_REFILL;
                  end
               end
               // New fetch enters the stage while the old one leaves
               tag_read_req_o = fetch_req_i & fetch_gnt_o;
               if (fetch_gnt_o)
               begin
                  pend_d = fetch_req_i;
               end
            end
         end

         // FIFO full, hold the push; tag data stays valid, no new read
         REQ_REFILL:
         begin
            push_valid_o = 1'b1;
            if (push_gnt_i)
            begin
               fetch_rvalid_o = 1'b1;
               pend_d         = 1'b0;
               state_d        = bypass_icache_i ? ENTER_BYPASS : OPERATIVE;
            end
         end

         // Wait for the rest of the system to confirm bypass
         ENTER_BYPASS:
         begin
            cache_is_bypassed_o = 1'b1;
            if (bypass_done_i)
            begin
               state_d = DISABLED;
            end
         end

         default:
         begin
            state_d = DISABLED;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- design/icache_bank.sv
/*
 * Instruction cache bank, top level
 * Connects the bank FSM, the tag compare, the replacement LFSR
 * and the miss FIFO that feeds refills to the main cache controller
 */

`timescale 1ns/1ns
`default_nettype none

module icache_bank
(
   input  wire logic                                 clk,
   input  wire logic                                 rst_n,
   // Fetch side
   input  wire logic                                 fetch_req_i,
   input  wire logic [icache_bank_pkg::ADDR_W-1:0]   fetch_addr_i,
   output logic                                      fetch_gnt_o,
   output logic                                      fetch_rvalid_o,
   // Tag memory read port
   output logic                                      tag_read_req_o,
   output logic [icache_bank_pkg::SET_W-1:0]         tag_read_set_o,
   input  wire icache_bank_pkg::tag_ways_t           tag_rdata_i,
   // Refill requests toward the main controller
   output logic                                      refill_valid_o,
   output icache_bank_pkg::refill_req_t              refill_req_o,
   input  wire logic                                 refill_gnt_i,
   // Mode levels
   input  wire logic                                 bypass_icache_i,
   input  wire logic                                 refill_idle_i,
   input  wire logic                                 bypass_done_i,
   output logic                                      cache_is_bypassed_o
);
   import icache_bank_pkg::*;

   logic              hit;
   logic              all_valid;
   way_oh_t           free_way;
   way_oh_t           rand_way;
   logic              lfsr_step;
   logic [ADDR_W-1:0] pend_addr;
   logic              push_valid;
   logic              push_gnt;
   refill_req_t       push_data;

   icache_bank_ctrl i_ctrl (
      .clk                 (clk),
      .rst_n               (rst_n),
      .fetch_req_i         (fetch_req_i),
      .fetch_addr_i        (fetch_addr_i),
      .bypass_icache_i     (bypass_icache_i),
      .refill_idle_i       (refill_idle_i),
      .bypass_done_i       (bypass_done_i),
      .hit_i               (hit),
      .all_valid_i         (all_valid),
      .free_way_i          (free_way),
      .rand_way_i          (rand_way),
      .push_gnt_i          (push_gnt),
      .fetch_gnt_o         (fetch_gnt_o),
      .fetch_rvalid_o      (fetch_rvalid_o),
      .tag_read_req_o      (tag_read_req_o),
      .tag_read_set_o      (tag_read_set_o),
      .pend_addr_o         (pend_addr),
      .push_valid_o        (push_valid),
      .push_data_o         (push_data),
      .lfsr_step_o         (lfsr_step),
      .cache_is_bypassed_o (cache_is_bypassed_o)
   );

   // Compares against the ways returned for the registered fetch
   icache_tag_check i_tag_check (
      .tag_rdata_i (tag_rdata_i),
      .pend_addr_i (pend_addr),
      .hit_o       (hit),
      .all_valid_o (all_valid),
      .free_way_o  (free_way)
   );

   icache_way_lfsr i_way_lfsr (
      .clk        (clk),
      .rst_n      (rst_n),
      .step_i     (lfsr_step),
      .rand_way_o (rand_way)
   );

   icache_miss_fifo i_miss_fifo (
      .clk          (clk),
      .rst_n        (rst_n),
      .push_valid_i (push_valid),
      .push_data_i  (push_data),
      .push_gnt_o   (push_gnt),
      .pop_valid_o  (refill_valid_o),
      .pop_data_o   (refill_req_o),
      .pop_gnt_i    (refill_gnt_i)
   );

endmodule

`default_nettype wire

//--- dv/icache_bank_sva.sv
/*
 * Protocol assertions for the bank controller
 * Held refill pushes, fetch grant per state, one-hot victim way
 */

`timescale 1ns/1ns
`default_nettype none

module icache_bank_sva
(
   input  wire logic                          clk,
   input  wire logic                          rst_n,
   input  wire icache_bank_pkg::bank_state_e  state_q,
   input  wire logic                          fetch_gnt_o,
   input  wire logic                          push_valid_o,
   input  wire logic                          push_gnt_i,
   input  wire icache_bank_pkg::refill_req_t  push_data_o
);
   import icache_bank_pkg::*;

   int assert_fails = 0;

   // A push that is not granted stays up with the same request
   held_push_stable: assert property (@(posedge clk) disable iff (!rst_n)
      push_valid_o && !push_gnt_i |=> push_valid_o && $stable(push_data_o))
      else
      begin
         $error("refill push dropped or changed before its grant");
         assert_fails++;
      end

   // Fetches are only granted while disabled or operative
   gnt_only_when_open: assert property (@(posedge clk) disable iff (!rst_n)
      (state_q inside {WAIT_IDLE, REQ_REFILL, ENTER_BYPASS}) |-> !fetch_gnt_o)
      else
      begin
         $error("fetch granted in a closed state");
         assert_fails++;
      end

   push_way_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      push_valid_o |-> $onehot(push_data_o.way))
      else
      begin
         $error("victim way is not one-hot");
         assert_fails++;
      end

endmodule

bind icache_bank_ctrl icache_bank_sva i_sva (.*);

`default_nettype wire

//--- dv/icache_bank_checker.sv
/*
 * Checker for the cache bank
 * Predicts hit or miss from the returned tag ways, the victim way
 * and the order of refills, and compares them with the DUT ports
 */

`timescale 1ns/1ns
`default_nettype none

module icache_bank_checker
(
   input  wire logic                                 clk,
   input  wire logic                                 rst_n,
   input  wire logic [icache_bank_pkg::ADDR_W-1:0]   fetch_addr_i,
   input  wire logic                                 fetch_gnt_o,
   input  wire logic                                 fetch_rvalid_o,
   input  wire logic                                 tag_read_req_o,
   input  wire logic [icache_bank_pkg::SET_W-1:0]    tag_read_set_o,
   input  wire icache_bank_pkg::tag_ways_t           tag_rdata_i,
   input  wire logic                                 refill_valid_o,
   input  wire icache_bank_pkg::refill_req_t         refill_req_o,
   input  wire logic                                 refill_gnt_i,
   input  wire logic                                 bypass_icache_i
);
   import icache_bank_pkg::*;

   refill_req_t       exp_q[$];
   // Own copy of the replacement LFSR with taps 8 6 5 4 and seed 1
   logic [7:0]        repl_lfsr = 8'd1;
   logic              chk_pend = 1'b0;
   logic [ADDR_W-1:0] chk_addr;
   int                outstanding = 0;
   string             test_name = "none";
   int                test_errs = 0;
   int                total_errs = 0;
   int                tests_run = 0;
   int                tests_failed = 0;
   int                hits = 0;
   int                misses = 0;

   ////////////////////
   // Reporting
   ////////////////////

   task automatic start_test(input string name);
      test_name = name;
      test_errs = 0;
   endtask

   task automatic fail_check(input string what);
      $display("Error in %s: %s", test_name, what);
      test_errs++;
      total_errs++;
   endtask

   task automatic mismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
      $display("Mismatch in %s: %s expected %h actual %h", test_name, what, exp, act);
      test_errs++;
      total_errs++;
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (act !== exp)
      begin
         mismatch(what, 64'(exp), 64'(act));
      end
   endtask

   task automatic end_test();
      tests_run++;
      if (test_errs != 0)
      begin
         tests_failed++;
      end
      $display("Test %s: %s (%0d errors)", test_name, (test_errs == 0) ? "ok" : "failed",
               test_errs);
   endtask

   // FIFO full plus one push held in the controller
   task automatic check_backpressure();
      check_bit("fetch_gnt_o while full", 1'b0, fetch_gnt_o);
      check_bit("refill_valid_o while full", 1'b1, refill_valid_o);
      if (exp_q.size() != MISS_FIFO_DEPTH + 1)
      begin
         mismatch("queued misses", 64'(MISS_FIFO_DEPTH + 1), 64'(exp_q.size()));
      end
   endtask

   function automatic bit drained();
      return (exp_q.size() == 0) && (outstanding == 0) && !chk_pend;
   endfunction

   ////////////////////
   // Prediction
   ////////////////////

   always @(posedge clk)
   begin
      logic             hit;
      logic             all_valid;
      logic             exp_rvalid;
      way_oh_t          free;
      refill_req_t      exp;
      logic [TAG_W-1:0] tag;

      if (!rst_n)
      begin
         repl_lfsr   = 8'd1;
         chk_pend    = 1'b0;
         outstanding = 0;
         exp_q.delete();
      end
      else
      begin
         if (chk_pend)
         begin
            hit       = 1'b0;
            all_valid = 1'b1;
            free      = '0;
            tag       = chk_addr[TAG_LSB +: TAG_W];
            // Highest invalid way first
            for (int w = NB_WAYS - 1; w >= 0; w--)
            begin
               if (tag_rdata_i[w].valid && tag_rdata_i[w].tag == tag)
               begin
                  hit = 1'b1;
               end
               if (!tag_rdata_i[w].valid)
               begin
                  all_valid = 1'b0;
                  if (free == '0)
                  begin
                     free[w] = 1'b1;
                  end
               end
            end
            if (hit)
            begin
               hits++;
               check_bit("fetch_rvalid_o on hit", 1'b1, fetch_rvalid_o);
            end
            else
            begin
               misses++;
               exp.addr = chk_addr;
               exp.way  = all_valid ? (way_oh_t'(1) << repl_lfsr[1:0]) : free;
               if (all_valid)
               begin
                  repl_lfsr = {repl_lfsr[6:0],
                               repl_lfsr[7] ^ repl_lfsr[5] ^ repl_lfsr[4] ^ repl_lfsr[3]};
               end
               // Queue entries before this push match the FIFO fill level
               exp_rvalid = !bypass_icache_i && (exp_q.size() < MISS_FIFO_DEPTH);
               check_bit("fetch_rvalid_o on miss", exp_rvalid, fetch_rvalid_o);
               exp_q.push_back(exp);
               if (!exp_rvalid)
               begin
                  outstanding++;
               end
            end
            chk_pend = 1'b0;
         end
         else if (fetch_rvalid_o)
         begin
            if (outstanding == 0)
            begin
               fail_check("fetch_rvalid_o without a pending fetch");
            end
            else
            begin
               outstanding--;
            end
         end

         // Refills leave in miss order
         if (refill_valid_o && refill_gnt_i)
         begin
            if (exp_q.size() == 0)
            begin
               fail_check("refill delivered with no miss behind it");
            end
            else
            begin
               exp = exp_q.pop_front();
               if (refill_req_o !== exp)
               begin
                  mismatch("refill_req_o", 64'(exp), 64'(refill_req_o));
               end
            end
         end

         if (tag_read_req_o)
         begin
            if (tag_read_set_o !== fetch_addr_i[SET_LSB +: SET_W])
            begin
               mismatch("tag_read_set_o", 64'(fetch_addr_i[SET_LSB +: SET_W]),
                        64'(tag_read_set_o));
            end
            chk_pend = 1'b1;
            chk_addr = fetch_addr_i;
         end
      end
   end

endmodule

`default_nettype wire

//--- dv/tb_icache_bank.sv
/*
 * Testbench for the instruction cache bank
 * Clock, reset, random fetch traffic, tag memory model and a
 * refill responder that writes granted refills back into the tags
 */

`timescale 1ns/1ns
`default_nettype none

module tb_icache_bank;
   import icache_bank_pkg::*;

   logic              clk;
   logic              rst_n;
   logic              fetch_req;
   logic [ADDR_W-1:0] fetch_addr;
   logic              fetch_gnt;
   logic              fetch_rvalid;
   logic              tag_read_req;
   logic [SET_W-1:0]  tag_read_set;
   tag_ways_t         tag_rdata;
   logic              refill_valid;
   refill_req_t       refill_req;
   logic              refill_gnt;
   logic              bypass_icache;
   logic              refill_idle;
   logic              bypass_done;
   logic              cache_is_bypassed;
   tag_ways_t         tag_mem [2**SET_W];
   logic [7:0]        stim_lfsr = 8'd89;

   icache_bank i_dut (
      .clk                 (clk),
      .rst_n               (rst_n),
      .fetch_req_i         (fetch_req),
      .fetch_addr_i        (fetch_addr),
      .fetch_gnt_o         (fetch_gnt),
      .fetch_rvalid_o      (fetch_rvalid),
      .tag_read_req_o      (tag_read_req),
      .tag_read_set_o      (tag_read_set),
      .tag_rdata_i         (tag_rdata),
      .refill_valid_o      (refill_valid),
      .refill_req_o        (refill_req),
      .refill_gnt_i        (refill_gnt),
      .bypass_icache_i     (bypass_icache),
      .refill_idle_i       (refill_idle),
      .bypass_done_i       (bypass_done),
      .cache_is_bypassed_o (cache_is_bypassed)
   );

   icache_bank_checker i_chk (
      .clk             (clk),
      .rst_n           (rst_n),
      .fetch_addr_i    (fetch_addr),
      .fetch_gnt_o     (fetch_gnt),
      .fetch_rvalid_o  (fetch_rvalid),
      .tag_read_req_o  (tag_read_req),
      .tag_read_set_o  (tag_read_set),
      .tag_rdata_i     (tag_rdata),
      .refill_valid_o  (refill_valid),
      .refill_req_o    (refill_req),
      .refill_gnt_i    (refill_gnt),
      .bypass_icache_i (bypass_icache)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #2 clk = ~clk;
      end
   end

   ////////////////////
   // Memory models
   ////////////////////

   // Registered read port and a write port for granted refills
   always @(posedge clk)
   begin
      if (tag_read_req)
      begin
         tag_rdata <= tag_mem[tag_read_set];
      end
      if (refill_valid && refill_gnt)
      begin
         for (int w = 0; w < NB_WAYS; w++)
         begin
            if (refill_req.way[w])
            begin
               tag_mem[refill_req.addr[SET_LSB +: SET_W]][w] <=
                  {1'b1, refill_req.addr[TAG_LSB +: TAG_W]};
            end
         end
      end
   end

   // Stimulus LFSR stepped once per bit
   function automatic logic [7:0] take_bits(input int n);
      logic [7:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         stim_lfsr = {stim_lfsr[6:0], stim_lfsr[7] ^ stim_lfsr[5] ^ stim_lfsr[4] ^ stim_lfsr[3]};
         r = {r[6:0], stim_lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
                                                   input logic [SET_W-1:0] set,
                                                   input logic [OFFSET_W-1:0] off);
      return {{(ADDR_W - TAG_LSB - TAG_W){1'b0}}, tag, set, off};
   endfunction

   // Stop fetching, grant every refill, wait for the bank to empty
   task automatic drain();
      int cnt;
      cnt = 0;
      fetch_req  = 1'b0;
      refill_gnt = 1'b1;
      while (!i_chk.drained() && cnt < 300)
      begin
         @(negedge clk);
         cnt++;
      end
      if (!i_chk.drained())
      begin
         i_chk.fail_check("bank did not drain its misses and refills");
      end
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial
   begin
      int cnt;
      rst_n         = 1'b0;
      fetch_req     = 1'b0;
      fetch_addr    = '0;
      refill_gnt    = 1'b0;
      bypass_icache = 1'b1;
      refill_idle   = 1'b0;
      bypass_done   = 1'b0;
      tag_rdata     = '0;
      for (int s = 0; s < 2**SET_W; s++)
      begin
         tag_mem[s] = '0;
      end
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // Reset values and the enable through WAIT_IDLE
      @(negedge clk);
      i_chk.start_test("reset_enable");
      i_chk.check_bit("cache_is_bypassed_o", 1'b1, cache_is_bypassed);
      i_chk.check_bit("fetch_gnt_o", 1'b1, fetch_gnt);
      i_chk.check_bit("fetch_rvalid_o", 1'b0, fetch_rvalid);
      i_chk.check_bit("tag_read_req_o", 1'b0, tag_read_req);
      i_chk.check_bit("refill_valid_o", 1'b0, refill_valid);
      bypass_icache = 1'b0;
      repeat (3) @(negedge clk);
      i_chk.check_bit("bypassed while refill path busy", 1'b1, cache_is_bypassed);
      refill_idle = 1'b1;
      cnt = 0;
      while (cache_is_bypassed && cnt < 50)
      begin
         @(negedge clk);
         cnt++;
      end
      if (cache_is_bypassed)
      begin
         i_chk.fail_check("cache did not leave bypass after enable");
      end
      i_chk.end_test();

      // Eight tags on two sets give hits and both kinds of victim
      i_chk.start_test("random_traffic");
      repeat (600)
      begin
         @(negedge clk);
         fetch_req  = (take_bits(2) != 0);
         fetch_addr = make_addr(TAG_W'(take_bits(3)), SET_W'(take_bits(1)),
                                OFFSET_W'(take_bits(4)));
         refill_gnt = (take_bits(2) != 0);
      end
      drain();
      i_chk.end_test();

      // Fresh tags always miss while no refill is granted
      i_chk.start_test("backpressure");
      refill_gnt = 1'b0;
      for (int k = 0; k < 40; k++)
      begin
         @(negedge clk);
         fetch_req  = 1'b1;
         fetch_addr = make_addr(TAG_W'(8'h80 + k), SET_W'(take_bits(1)), '0);
      end
      i_chk.check_backpressure();
      drain();
      i_chk.end_test();

      // Disable with one fetch in flight
      i_chk.start_test("disable");
      @(negedge clk);
      fetch_req  = 1'b1;
      fetch_addr = make_addr(TAG_W'(take_bits(3)), '0, '0);
      cnt = 0;
      while (!fetch_gnt && cnt < 50)
      begin
         @(negedge clk);
         cnt++;
      end
      if (!fetch_gnt)
      begin
         i_chk.fail_check("no fetch grant before the disable");
      end
      @(negedge clk);
      fetch_req     = 1'b0;
      bypass_icache = 1'b1;
      cnt = 0;
      while (!cache_is_bypassed && cnt < 50)
      begin
         @(negedge clk);
         cnt++;
      end
      if (!cache_is_bypassed)
      begin
         i_chk.fail_check("cache did not enter bypass after disable");
      end
      repeat (4)
      begin
         @(negedge clk);
         i_chk.check_bit("fetch_gnt_o before bypass_done_i", 1'b0, fetch_gnt);
      end
      if (!i_chk.drained())
      begin
         i_chk.fail_check("pending fetch did not complete before bypass");
      end
      bypass_done = 1'b1;
      cnt = 0;
      while (!fetch_gnt && cnt < 50)
      begin
         @(negedge clk);
         cnt++;
      end
      if (!fetch_gnt)
      begin
         i_chk.fail_check("no fetch grant after bypass_done_i");
      end
      bypass_done = 1'b0;
      i_chk.end_test();

      $display("%0d tests, %0d failed, %0d errors, %0d assertion failures, %0d hits, %0d misses",
               i_chk.tests_run, i_chk.tests_failed, i_chk.total_errs,
               i_dut.i_ctrl.i_sva.assert_fails, i_chk.hits, i_chk.misses);
      if (i_chk.total_errs == 0 && i_chk.tests_failed == 0 &&
          i_dut.i_ctrl.i_sva.assert_fails == 0)
      begin
         $display("=== PASS ===");
      end
      else
      begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // Watchdog for the whole run
   initial
   begin
      #100000;
      $display("Simulation did not finish in time");
      $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

//--- icache_bank.f
design/icache_bank_pkg.sv
design/icache_way_lfsr.sv
design/icache_tag_check.sv
design/icache_miss_fifo.sv
design/icache_bank_ctrl.sv
design/icache_bank.sv
dv/icache_bank_sva.sv
dv/icache_bank_checker.sv
dv/tb_icache_bank.sv

//--- Bender.yml
package:
  name: icache_bank

sources:
  - files:
      - design/icache_bank_pkg.sv
      - design/icache_way_lfsr.sv
      - design/icache_tag_check.sv
      - design/icache_miss_fifo.sv
      - design/icache_bank_ctrl.sv
      - design/icache_bank.sv
  - target: test
    files:
      - dv/icache_bank_sva.sv
      - dv/icache_bank_checker.sv
      - dv/tb_icache_bank.sv
